/* include/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ====================
// fetch stage settings
// ====================

// first instruction after reset.
`define FETCH_RESET_PC 32'h8000_0000

// cache geometry.
`define LINE_WORDS 4
`define LINE_COUNT 16

// top nibbles of the burst-capable sdram window.
`define SDRAM_NIBBLE_LO 4'hA
`define SDRAM_NIBBLE_HI 4'hB

`endif

/* source/axi_pkg.sv */
package axi_pkg;

    // ====================
    // axi read channel
    // ====================

    // burst kinds in use here.
    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01
    } axi_burst_e;

    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

    // beats minus one.
    typedef logic [7:0] axi_len_t;

endpackage

/* source/fetch_pkg.sv */
`include "fetch_settings.svh"

package fetch_pkg;

    localparam int WORD_BITS  = $clog2(`LINE_WORDS);
    localparam int INDEX_BITS = $clog2(`LINE_COUNT);
    localparam int TAG_BITS   = 32 - INDEX_BITS - WORD_BITS - 2;

    // address fields as the cache sees them.
    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [INDEX_BITS-1:0] index;
        logic [WORD_BITS-1:0]  word;
        logic [1:0]            byte_off;
    } fetch_addr_t;

    typedef union packed {
        logic [31:0] raw;
        fetch_addr_t f;
    } fetch_addr_u;

    typedef logic [`LINE_WORDS-1:0][31:0] cache_line_t;

    typedef enum logic [1:0] {
        LOOKUP,
        REFILL,
        WAIT_FILL
    } fetch_state_e;

endpackage

// ====================
// interfaces
// ====================

// controller to refill engine, one pulse each way.
interface refill_if import fetch_pkg::*; ();
    logic        start;
    fetch_addr_u line_addr;
    logic        burst_mode;
    logic        done;
    logic        fault;
    cache_line_t line;

    modport ctrl (output start, line_addr, burst_mode, input done, fault, line);
    modport engine (input start, line_addr, burst_mode, output done, fault, line);
endinterface

interface fill_if import fetch_pkg::*; ();
    logic                  fill_en;
    logic [INDEX_BITS-1:0] fill_index;
    logic [TAG_BITS-1:0]   fill_tag;
    cache_line_t           fill_line;

    modport engine (output fill_en, fill_index, fill_tag, fill_line);
    modport cache (input fill_en, fill_index, fill_tag, fill_line);
endinterface

interface count_if import fetch_pkg::*; ();
    logic                 clear;
    logic                 step;
    logic [WORD_BITS-1:0] beat;
    logic                 last;

    modport user (output clear, step, input beat, last);
    modport counter (input clear, step, output beat, last);
endinterface

/* source/fetch_ctrl.sv */
`include "fetch_settings.svh"

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        decode_ready,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output logic        inst_valid,
    output logic [31:0] inst,
    output logic [31:0] inst_pc,
    output logic        access_fault,
    output fetch_addr_u lookup_addr,
    input  logic        hit,
    input  logic [31:0] hit_word,
    refill_if.ctrl      refill
);

    fetch_state_e state;
    logic [31:0]  pc;
    logic [31:0]  next_pc;
    logic         fault_pending;
    logic         in_sdram;
    fetch_addr_u  line_base;

    assign lookup_addr.raw = pc;

    // redirect wins over the sequential pc.
    assign next_pc = redirect_valid ? redirect_pc : pc + 32'd4;

    assign in_sdram = (lookup_addr.raw[31:28] == `SDRAM_NIBBLE_LO) ||
                      (lookup_addr.raw[31:28] == `SDRAM_NIBBLE_HI);

    always_comb begin
        line_base = lookup_addr;
        line_base.f.word = '0;
        line_base.f.byte_off = '0;
    end

    // ====================
    // state machine
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= LOOKUP;
            pc            <= `FETCH_RESET_PC;
            inst_valid    <= 1'b0;
            access_fault  <= 1'b0;
            fault_pending <= 1'b0;
            refill.start  <= 1'b0;
        end else begin
            refill.start <= 1'b0;
            case (state)
                LOOKUP: begin
                    // nothing moves while decode stalls.
                    if (decode_ready) begin
                        inst_valid   <= 1'b0;
                        access_fault <= 1'b0;
                        if (fault_pending || hit) begin
                            inst_valid    <= !redirect_valid;
                            access_fault  <= fault_pending;
                            fault_pending <= 1'b0;
                            pc            <= next_pc;
                        end else begin
                            refill.start <= 1'b1;
                            state        <= REFILL;
                        end
                    end
                end
                REFILL: begin
                    if (refill.done) begin
                        fault_pending <= refill.fault;
                        state         <= WAIT_FILL;
                    end
                end
                // line lands in the array during this cycle.
                WAIT_FILL: begin
                    state <= LOOKUP;
                end
                default: begin
                    state <= LOOKUP;
                end
            endcase
        end
    end

    // instruction payload and refill request.
    always_ff @(posedge clk) begin
        if (state == LOOKUP && decode_ready) begin
            inst              <= fault_pending ? 32'd0 : hit_word;
            inst_pc           <= pc;
            refill.line_addr  <= line_base;
            refill.burst_mode <= in_sdram;
        end
    end

    // a refill only leaves from lookup.
    a_start_from_lookup: assert property (@(posedge clk) disable iff (rst)
        refill.start |-> $past(state) == LOOKUP && state == REFILL);

endmodule

/* source/beat_counter.sv */
`include "fetch_settings.svh"

module beat_counter
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    count_if.counter  cnt
);

    localparam logic [WORD_BITS-1:0] LAST_BEAT = WORD_BITS'(`LINE_WORDS - 1);

    // ====================
    // beat index
    // ====================

    // wraps to zero after the last word.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt.beat <= '0;
        end else if (cnt.clear) begin
            cnt.beat <= '0;
        end else if (cnt.step) begin
            cnt.beat <= cnt.beat + 1'b1;
        end
    end

    assign cnt.last = (cnt.beat == LAST_BEAT);

    // the engine stops stepping once the line is complete.
    a_no_step_after_wrap: assert property (@(posedge clk) disable iff (rst)
        (cnt.step && cnt.last && !cnt.clear) |=> !cnt.step);

endmodule

/* source/refill_engine.sv */
`include "fetch_settings.svh"

module refill_engine
    import axi_pkg::*;
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    refill_if.engine    refill,
    fill_if.engine      fill,
    count_if.user       cnt,
    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    output axi_len_t    arlen,
    output logic [2:0]  arsize,
    output axi_burst_e  arburst,
    output logic [3:0]  arid,
    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    fetch_addr_u beat_addr;
    logic        beat_fire;
    logic        line_end;
    logic        next_single;

    assign beat_fire   = rvalid && rready;
    assign line_end    = refill.burst_mode ? rlast : cnt.last;
    assign next_single = beat_fire && !line_end && !refill.burst_mode;

    assign cnt.clear = refill.start;
    assign cnt.step  = beat_fire;

    // word 0 at start, then the word after the current beat.
    always_comb begin
        beat_addr = refill.line_addr;
        beat_addr.f.word = refill.start ? '0 : cnt.beat + 1'b1;
    end

    assign arlen   = refill.burst_mode ? axi_len_t'(`LINE_WORDS - 1) : '0;
    assign arburst = refill.burst_mode ? AXI_BURST_INCR : AXI_BURST_FIXED;
    assign arsize  = 3'd2;
    assign arid    = 4'd0;

    // ====================
    // ar and r sequencing
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arvalid      <= 1'b0;
            rready       <= 1'b0;
            refill.done  <= 1'b0;
            refill.fault <= 1'b0;
        end else begin
            refill.done <= 1'b0;
            if (refill.start) begin
                arvalid      <= 1'b1;
                refill.fault <= 1'b0;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end else if (beat_fire) begin
                refill.fault <= refill.fault || (rresp != AXI_RESP_OKAY);
                if (line_end) begin
                    rready      <= 1'b0;
                    refill.done <= 1'b1;
                end else if (!refill.burst_mode) begin
                    rready  <= 1'b0;
                    arvalid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill.start || next_single) begin
            araddr <= beat_addr.raw;
        end
        if (beat_fire) begin
            refill.line[cnt.beat] <= rdata;
        end
    end

    // faulted lines never reach the array.
    assign fill.fill_en    = refill.done && !refill.fault;
    assign fill.fill_index = refill.line_addr.f.index;
    assign fill.fill_tag   = refill.line_addr.f.tag;
    assign fill.fill_line  = refill.line;

    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    a_rlast_match: assert property (@(posedge clk) disable iff (rst)
        beat_fire && refill.burst_mode |-> rlast == cnt.last);

    // single id in flight.
    a_rid_match: assert property (@(posedge clk) disable iff (rst)
        beat_fire |-> rid == arid);

endmodule

/* source/icache_array.sv */
`include "fetch_settings.svh"

module icache_array
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_addr_u lookup_addr,
    output logic        hit,
    output logic [31:0] hit_word,
    fill_if.cache       fill
);

    logic [`LINE_COUNT-1:0] valid;
    logic [TAG_BITS-1:0]    tags [`LINE_COUNT];
    cache_line_t            lines [`LINE_COUNT];

    // ====================
    // storage
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill.fill_en) begin
            valid[fill.fill_index] <= 1'b1;
        end
    end

    // whole line written at once.
    always_ff @(posedge clk) begin
        if (fill.fill_en) begin
            tags[fill.fill_index]  <= fill.fill_tag;
            lines[fill.fill_index] <= fill.fill_line;
        end
    end

    // ====================
    // lookup
    // ====================

    assign hit = valid[lookup_addr.f.index] &&
                 (tags[lookup_addr.f.index] == lookup_addr.f.tag);

    // word select by offset, only meaningful on a hit.
    assign hit_word = lines[lookup_addr.f.index][lookup_addr.f.word];

endmodule

/* source/fetch_top.sv */
module fetch_top
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // decode side.
    output logic        inst_valid,
    output logic [31:0] inst,
    output logic [31:0] inst_pc,
    output logic        access_fault,
    input  logic        decode_ready,
    // execute side.
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    // axi ar.
    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic [3:0]  arid,
    // axi r.
    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    fetch_addr_u lookup_addr;
    logic        hit;
    logic [31:0] hit_word;

    refill_if refill ();
    fill_if   fill ();
    count_if  cnt ();

    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .decode_ready   (decode_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .access_fault   (access_fault),
        .lookup_addr    (lookup_addr),
        .hit            (hit),
        .hit_word       (hit_word),
        .refill         (refill.ctrl)
    );

    beat_counter u_counter (
        .clk (clk),
        .rst (rst),
        .cnt (cnt.counter)
    );

    refill_engine u_refill (
        .clk     (clk),
        .rst     (rst),
        .refill  (refill.engine),
        .fill    (fill.engine),
        .cnt     (cnt.user),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arid    (arid),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rid     (rid)
    );

    icache_array u_cache (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_word    (hit_word),
        .fill        (fill.cache)
    );

endmodule

/* tests/axi_mem_model.sv */
`include "fetch_settings.svh"

module axi_mem_model
    import axi_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stall_ar,
    input  logic        stall_r,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic [2:0]  arsize,
    input  logic [1:0]  arburst,
    input  logic [3:0]  arid,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic [3:0]  rid,
    output int          ar_count,
    output int          burst_count,
    output int          error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        busy;
    logic [31:0] addr_q;
    axi_len_t    left;
    logic [3:0]  id_q;
    logic        in_window;
    axi_burst_e  exp_burst;
    axi_len_t    exp_len;

    function automatic logic [31:0] mem_word(logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h1234_5678;
    endfunction

    function automatic logic mem_fault(logic [31:0] addr);
        return (addr >= 32'h9000_0000) && (addr <= 32'h9000_00FF);
    endfunction

    // one transaction at a time.
    assign arready   = !busy && !stall_ar;
    assign in_window = (araddr[31:28] == `SDRAM_NIBBLE_LO) ||
                       (araddr[31:28] == `SDRAM_NIBBLE_HI);
    assign exp_burst = in_window ? AXI_BURST_INCR : AXI_BURST_FIXED;
    assign exp_len   = in_window ? 8'd3 : 8'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            addr_q      <= '0;
            left        <= '0;
            id_q        <= '0;
            rvalid      <= 1'b0;
            rdata       <= '0;
            rresp       <= AXI_RESP_OKAY;
            rlast       <= 1'b0;
            rid         <= '0;
            ar_count    <= 0;
            burst_count <= 0;
            error_count <= 0;
        end else begin
            if (arvalid && arready) begin
                busy     <= 1'b1;
                addr_q   <= araddr;
                left     <= arlen;
                id_q     <= arid;
                ar_count <= ar_count + 1;
                if (arburst == AXI_BURST_INCR) begin
                    burst_count <= burst_count + 1;
                end
                // id, size, burst and length as one field.
                if ({arid, arsize, arburst, arlen} !==
                    {4'd0, 3'd2, exp_burst, exp_len}) begin
                    $display("CHECK FAILED ar_kind at %h expected %h actual %h", araddr,
                             {4'd0, 3'd2, exp_burst, exp_len},
                             {arid, arsize, arburst, arlen});
                    error_count <= error_count + 1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                if (left == 8'd0) begin
                    busy <= 1'b0;
                end else begin
                    left   <= left - 8'd1;
                    addr_q <= addr_q + 32'd4;
                end
            end else if (busy && !rvalid && !stall_r) begin
                rvalid <= 1'b1;
                rdata  <= mem_word(addr_q);
                rresp  <= mem_fault(addr_q) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
                rlast  <= (left == 8'd0);
                rid    <= id_q;
            end
        end
    end

endmodule

/* tests/fetch_tb.sv */
`include "fetch_settings.svh"

module fetch_tb
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEQ_INSTS     = 24;
    localparam int SDRAM_INSTS   = 12;
    localparam int FAULT_INSTS   = 8;
    localparam int REVISIT_INSTS = 4;
    localparam int RANDOM_SEGS   = 4;
    localparam int SEG_INSTS     = 10;
    localparam int SQUASH_INSTS  = 4;
    localparam int TOTAL_INSTS   = 2 * SEQ_INSTS + SDRAM_INSTS + FAULT_INSTS +
                                   REVISIT_INSTS + RANDOM_SEGS * SEG_INSTS + 2 * SQUASH_INSTS;
    localparam int WATCHDOG_CYCLES = 16 + 400 * TOTAL_INSTS;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        decode_ready = 1'b0;
    logic        redirect_valid = 1'b0;
    logic [31:0] redirect_pc = '0;
    logic        stall_ar = 1'b0;
    logic        stall_r = 1'b0;
    logic        inst_valid, access_fault, arvalid, arready, rvalid, rready, rlast;
    logic [31:0] inst, inst_pc, araddr, rdata;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst, rresp;
    logic [3:0]  arid, rid;
    int          ar_count, burst_count, bus_errors;

    logic [31:0] rand_state = 32'h5f45;
    logic        random_ready = 1'b0;
    logic        redirect_req = 1'b0;
    logic        redirect_taken = 1'b0;
    logic [31:0] redirect_target = '0;
    logic [31:0] exp_pc = `FETCH_RESET_PC;
    logic [31:0] last_pc = '0;
    int          delivered = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    string       test_name = "reset";
    logic        advance;

    fetch_top DUT (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc),
        .access_fault(access_fault), .decode_ready(decode_ready),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arlen(arlen),
        .arsize(arsize), .arburst(arburst), .arid(arid), .rvalid(rvalid), .rready(rready),
        .rdata(rdata), .rresp(rresp), .rlast(rlast), .rid(rid)
    );

    axi_mem_model u_mem (
        .clk(clk), .rst(rst), .stall_ar(stall_ar), .stall_r(stall_r),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arlen(arlen),
        .arsize(arsize), .arburst(arburst), .arid(arid), .rvalid(rvalid), .rready(rready),
        .rdata(rdata), .rresp(rresp), .rlast(rlast), .rid(rid), .ar_count(ar_count),
        .burst_count(burst_count), .error_count(bus_errors)
    );

    always #4 clk = ~clk;

    // the controller moves its pc on this edge.
    assign advance = (DUT.u_ctrl.state == LOOKUP) && decode_ready &&
                     (DUT.hit || DUT.u_ctrl.fault_pending);

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rand_state = lcg_next(rand_state);
        value = rand_state;
    endtask

    // fault flag on top of the expected word.
    function automatic logic [32:0] ref_fetch(logic [31:0] pc);
        if (pc >= 32'h9000_0000 && pc <= 32'h9000_00FF) begin
            return {1'b1, 32'd0};
        end
        return {1'b0, {pc[31:2], 2'b00} ^ 32'h1234_5678};
    endfunction

    function automatic logic [31:0] pick_target(logic [31:0] r);
        logic [31:0] base;
        base = r[31] ? 32'hA000_0000 : 32'h8000_0000;
        return base | {20'd0, r[11:2], 2'b00};
    endfunction

    task automatic report_mismatch(string field, logic [31:0] expected, logic [31:0] actual);
        $display("CHECK FAILED %s %s expected %h actual %h", test_name, field, expected, actual);
        value_errors = value_errors + 1;
    endtask

    task automatic wait_deliveries(int count);
        int target;
        target = delivered + count;
        wait (delivered >= target);
    endtask

    task automatic redirect_to(logic [31:0] target);
        redirect_target = target;
        redirect_req = 1'b1;
        wait (redirect_req == 1'b0);
        @(negedge clk);
    endtask

    task automatic check_squash(logic [31:0] target);
        redirect_to(target);
        wait_deliveries(1);
        if (last_pc !== target) begin
            report_mismatch("first_pc", target, last_pc);
        end
        wait_deliveries(SQUASH_INSTS - 1);
    endtask

    // ====================
    // stimulus
    // ====================

    always @(posedge clk) begin
        logic [31:0] r;
        draw_random(r);
        decode_ready <= random_ready ? (r[31:30] != 2'b00) : 1'b1;
        stall_ar     <= r[27];
        stall_r      <= r[26] & r[25];
        if (redirect_taken) begin
            redirect_valid <= 1'b0;
            redirect_taken = 1'b0;
            redirect_req = 1'b0;
        end else if (redirect_req) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= redirect_target;
        end
    end

    // ====================
    // tracker and compare
    // ====================

    always @(negedge clk) begin
        logic [32:0] expected;
        if (!rst) begin
            if (inst_valid && decode_ready) begin
                expected = ref_fetch(exp_pc);
                if (inst_pc !== exp_pc) begin
                    report_mismatch("inst_pc", exp_pc, inst_pc);
                end
                if (inst !== expected[31:0]) begin
                    report_mismatch("inst", expected[31:0], inst);
                end
                if (access_fault !== expected[32]) begin
                    report_mismatch("access_fault", {31'd0, expected[32]}, {31'd0, access_fault});
                end
                last_pc = inst_pc;
                delivered = delivered + 1;
                exp_pc = exp_pc + 32'd4;
            end
            // squashed fetch moves the pc to the target.
            if (advance && redirect_valid) begin
                exp_pc = redirect_pc;
                redirect_taken = 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d instructions delivered",
                 WATCHDOG_CYCLES, delivered, TOTAL_INSTS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          ar_mark;
        int          burst_mark;
        int          total;
        repeat (15) @(negedge clk);
        if ({inst_valid, access_fault, arvalid, rready} !== 4'b0000) begin
            report_mismatch("outputs", 32'd0, {28'd0, inst_valid, access_fault, arvalid, rready});
        end
        @(posedge clk);
        rst <= 1'b0;

        test_name = "sequential";
        wait_deliveries(SEQ_INSTS);

        test_name = "loop_hit";
        redirect_to(`FETCH_RESET_PC);
        ar_mark = ar_count;
        wait_deliveries(SEQ_INSTS);
        if (ar_count != ar_mark) begin
            report_mismatch("ar_count", ar_mark, ar_count);
        end

        test_name = "sdram_burst";
        redirect_to(32'hA000_0010);
        burst_mark = burst_count;
        wait_deliveries(SDRAM_INSTS);
        if (burst_count - burst_mark < SDRAM_INSTS / `LINE_WORDS) begin
            $display("sdram lines were not filled with INCR bursts, only %0d seen",
                     burst_count - burst_mark);
            other_errors = other_errors + 1;
        end

        test_name = "fault_region";
        redirect_to(32'h9000_0020);
        wait_deliveries(FAULT_INSTS);
        redirect_to(32'h9000_0020);
        ar_mark = ar_count;
        wait_deliveries(REVISIT_INSTS);
        if (ar_count - ar_mark < REVISIT_INSTS * `LINE_WORDS) begin
            $display("faulting line was served without a new refill on the second visit");
            other_errors = other_errors + 1;
        end

        test_name = "random_ready";
        random_ready = 1'b1;
        for (int seg = 0; seg < RANDOM_SEGS; seg++) begin
            draw_random(r);
            redirect_to(pick_target(r));
            wait_deliveries(SEG_INSTS);
        end
        random_ready = 1'b0;

        test_name = "redirect_squash";
        check_squash(32'h8000_0200);
        check_squash(32'hA000_0104);

        total = value_errors + bus_errors + other_errors;
        $display("summary: %0d instructions, value errors %0d, bus errors %0d, other errors %0d",
                 delivered, value_errors, bus_errors, other_errors);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+include
source/axi_pkg.sv
source/fetch_pkg.sv
source/fetch_ctrl.sv
source/beat_counter.sv
source/refill_engine.sv
source/icache_array.sv
source/fetch_top.sv
tests/axi_mem_model.sv
tests/fetch_tb.sv

/* Makefile */
# Verilator flow for the fetch stage testbench.

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK
VFLAGS    ?=

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/fetch_settings.svh
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
